// ==== common/bch_macros.svh ====
`ifndef BCH_MACROS_SVH
`define BCH_MACROS_SVH

// **************************************************
// BCH(15,7) code over GF(2^4)
// **************************************************

// Number of bits in one field element.
`define BCH_M 4

// Number of errors the code can correct.
// The locator polynomial has this many roots at most.
`define BCH_T 2

// Full code length, one Chien beat per codeword bit.
`define BCH_N 15

// Primitive polynomial x^4+x+1, the top bit is x^4.
`define BCH_POLY 5'h13

`endif

// ==== common/bch_pkg.sv ====
package bch_pkg;

`include "bch_macros.svh"

	typedef logic [`BCH_M-1:0] gf_elem_t;                 // One field element.
	typedef logic [(`BCH_T+1)*`BCH_M-1:0] sigma_t;        // Coefficient 0 sits in the low bits.
	typedef logic [$clog2(`BCH_N+1)-1:0] pos_t;           // Beat position within a codeword.
	typedef logic [$clog2(`BCH_N+1)-1:0] cnt_t;           // Number of roots found.

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_run,
		st_done
	} chien_state_t;

	// **************************************************
	// Field and counter helpers
	// **************************************************

	// Multiply by alpha, i.e. shift up and reduce by the primitive polynomial.
	function automatic gf_elem_t gf_mul_x(gf_elem_t a);
		gf_elem_t poly_low;
		poly_low = gf_elem_t'(`BCH_POLY);
		return {a[`BCH_M-2:0], 1'b0} ^ (a[`BCH_M-1] ? poly_low : gf_elem_t'(0));
	endfunction

	function automatic gf_elem_t alpha_pow(int n);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < n; i++) begin
			r = gf_mul_x(r);                                  // One more factor of alpha.
		end
		return r;
	endfunction

	// Taps x^4+x^3+1 give a period of 15 over the nonzero states.
	function automatic gf_elem_t lfsr_next(gf_elem_t s);
		return {s[2:0], s[3] ^ s[2]};
	endfunction

	function automatic gf_elem_t lfsr_count(int n);
		gf_elem_t s;
		s = gf_elem_t'(1);                                    // Same seed as the counter clear.
		for (int i = 0; i < n; i++) begin
			s = lfsr_next(s);
		end
		return s;
	endfunction

endpackage

// ==== hw/gf_mult.sv ====
`timescale 1ns/1ps

`include "bch_macros.svh"

module gf_mult (
	input  bch_pkg::gf_elem_t a,
	input  bch_pkg::gf_elem_t b,
	output bch_pkg::gf_elem_t p
);
	import bch_pkg::*;

	gf_elem_t acc;

	// Horner style, taking b from its top bit down.
	// Each round doubles the partial product and reduces it.
	always_comb begin
		acc = '0;
		for (int i = `BCH_M-1; i >= 0; i--) begin
			acc = gf_mul_x(acc);                              // Shift and reduce.
			if (b[i]) begin
				acc = acc ^ a;                                // Add a where b has a one.
			end
		end
	end

	assign p = acc;

endmodule

// ==== hw/lfsr_counter.sv ====
`timescale 1ns/1ps

module lfsr_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              clear,
	input  logic              step,
	output bch_pkg::gf_elem_t count
);
	import bch_pkg::*;

	// The all-zero state is a lock-up state, so clear goes to 1.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= gf_elem_t'(1);
		end else if (clear) begin
			count <= gf_elem_t'(1);                           // Restart the walk.
		end else if (step) begin
			count <= lfsr_next(count);                        // One step along the sequence.
		end
	end

endmodule

// ==== chien/chien_reg.sv ====
`timescale 1ns/1ps

module chien_reg #(
	parameter int POW = 1
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load,
	input  logic              step,
	input  bch_pkg::gf_elem_t coef,
	output bch_pkg::gf_elem_t term
);
	import bch_pkg::*;

	localparam gf_elem_t STEP_MUL = alpha_pow(POW);          // alpha^POW, fixed per term.

	gf_elem_t prod;

	gf_mult u_mult (
		.a(term),
		.b(STEP_MUL),
		.p(prod)
	);

	// After k steps the term holds coef * alpha^(POW*k).
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			term <= '0;
		end else if (load) begin
			term <= coef;                                     // New locator coefficient.
		end else if (step) begin
			term <= prod;
		end
	end

endmodule

// ==== chien/chien_search.sv ====
`timescale 1ns/1ps

`include "bch_macros.svh"

module chien_search (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  bch_pkg::sigma_t sigma,
	input  logic            accepted,
	output logic            busy,
	output logic            ready,
	output logic            beat_valid,
	output logic            last_beat,
	output bch_pkg::sigma_t terms
);
	import bch_pkg::*;

	localparam gf_elem_t FIRST_CNT = lfsr_count(0);           // Counter value on beat 0.
	localparam gf_elem_t LAST_CNT = lfsr_count(`BCH_N-1);     // Counter value on the last beat.

	chien_state_t state;
	chien_state_t state_nxt;
	gf_elem_t     count;
	logic         take_start;
	logic         beat_done;
	logic         reg_step;

	// **************************************************
	// Sequencer
	// **************************************************

	assign take_start = start && !busy;                      // Start is ignored mid search.
	assign beat_done = beat_valid && accepted;
	assign reg_step = (state == st_load) || beat_done;      // First multiply, then one per beat.

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle, st_done: state_nxt = take_start ? st_load : st_idle;
			st_load: state_nxt = st_run;
			st_run: begin
				if (beat_done && last_beat) begin
					state_nxt = st_done;
				end
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	assign busy = (state == st_load) || (state == st_run);
	assign beat_valid = (state == st_run);
	assign ready = beat_valid && (count == FIRST_CNT);        // Held until beat 0 is taken.
	assign last_beat = beat_valid && (count == LAST_CNT);

	lfsr_counter u_counter (
		.clk(clk),
		.rst_n(rst_n),
		.clear(state == st_load),
		.step(beat_done),
		.count(count)
	);

	// **************************************************
	// Term register bank
	// **************************************************

	for (genvar i = 0; i <= `BCH_T; i++) begin : g_term
		chien_reg #(
			.POW(i)
		) u_reg (
			.clk(clk),
			.rst_n(rst_n),
			.load(take_start),
			.step(reg_step),
			.coef(sigma[i*`BCH_M +: `BCH_M]),
			.term(terms[i*`BCH_M +: `BCH_M])
		);
	end

endmodule

// ==== hw/error_locator.sv ====
`timescale 1ns/1ps

`include "bch_macros.svh"

module error_locator (
	input  logic            clk,
	input  logic            rst_n,
	input  bch_pkg::sigma_t terms,
	input  logic            beat_valid,
	input  logic            first_beat,
	input  logic            last_beat,
	input  logic            accepted,
	output logic            err_flag,
	output bch_pkg::pos_t   position,
	output logic            done,
	output bch_pkg::cnt_t   err_count
);
	import bch_pkg::*;

	gf_elem_t sum;
	pos_t     pos_q;
	cnt_t     cnt_base;
	logic     beat_done;

	// **************************************************
	// Root detection
	// **************************************************

	// The sum of all terms is sigma evaluated at the current point.
	always_comb begin
		sum = '0;
		for (int i = 0; i <= `BCH_T; i++) begin
			sum = sum ^ terms[i*`BCH_M +: `BCH_M];
		end
	end

	assign err_flag = beat_valid && (sum == '0);             // A root marks an error bit.
	assign beat_done = beat_valid && accepted;

	// **************************************************
	// Position and error count
	// **************************************************

	// first_beat stands in for the cleared value, so beat 0 already reads zero.
	assign position = first_beat ? pos_t'(0) : pos_q;
	assign cnt_base = first_beat ? cnt_t'(0) : err_count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos_q <= '0;
			err_count <= '0;
			done <= 1'b0;
		end else begin
			done <= beat_done && last_beat;                   // One pulse after the last beat.
			if (beat_done) begin
				pos_q <= position + 1'b1;
				err_count <= cnt_base + cnt_t'(err_flag);     // No beats arrive after done.
			end
		end
	end

endmodule

// ==== hw/bch_chien_top.sv ====
`timescale 1ns/1ps

module bch_chien_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  bch_pkg::sigma_t sigma,
	input  logic            accepted,
	output logic            busy,
	output logic            ready,
	output logic            valid,
	output logic            err_flag,
	output bch_pkg::pos_t   position,
	output logic            done,
	output bch_pkg::cnt_t   err_count
);
	import bch_pkg::*;

	sigma_t terms;                                           // Evaluated terms of the current beat.
	logic   last_beat;

	// **************************************************
	// Search and locate
	// **************************************************

	chien_search u_search (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.sigma(sigma),
		.accepted(accepted),
		.busy(busy),
		.ready(ready),
		.beat_valid(valid),
		.last_beat(last_beat),
		.terms(terms)
	);

	// ready doubles as the first-beat marker.
	error_locator u_locator (
		.clk(clk),
		.rst_n(rst_n),
		.terms(terms),
		.beat_valid(valid),
		.first_beat(ready),
		.last_beat(last_beat),
		.accepted(accepted),
		.err_flag(err_flag),
		.position(position),
		.done(done),
		.err_count(err_count)
	);

endmodule

// ==== verif/chien_chk.sv ====
`timescale 1ns/1ps

module chien_chk (
	input logic          clk,
	input logic          rst_n,
	input logic          valid,
	input logic          accepted,
	input logic          err_flag,
	input bch_pkg::pos_t position,
	input logic          done
);
	int fail_count = 0;                                      // Read back by the testbench.

	// **************************************************
	// Handshake and reset properties
	// **************************************************

	// The registers clear on the edge that sees rst_n low.
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (!valid && !done))
	else begin
		fail_count++;
		$error("valid or done was high while reset was applied");
	end

	// A stalled beat keeps its flag and position.
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(valid && !accepted) |=> ($stable(err_flag) && $stable(position)))
	else begin
		fail_count++;
		$error("err_flag or position changed during a stalled beat");
	end

	a_done_alone: assert property (@(posedge clk) disable iff (!rst_n) !(done && valid))
	else begin
		fail_count++;
		$error("done and valid were high in the same cycle");
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
	else begin
		fail_count++;
		$error("done stayed high for more than one cycle");
	end

endmodule

bind bch_chien_top chien_chk u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.valid(valid),
	.accepted(accepted),
	.err_flag(err_flag),
	.position(position),
	.done(done)
);

// ==== verif/tb_bch_chien.sv ====
`timescale 1ns/1ps

`include "bch_macros.svh"

module tb_bch_chien;
	import bch_pkg::*;

	localparam int RUNS = 40;
	localparam int BEAT_TIMEOUT = 200;                       // Cycles without a transfer.

	logic     clk;
	logic     rst_n;
	logic     start;
	sigma_t   sigma;
	logic     accepted;
	logic     busy;
	logic     ready;
	logic     valid;
	logic     err_flag;
	pos_t     position;
	logic     done;
	cnt_t     err_count;

	int       checks;
	int       mismatches;
	int       failures;
	bit       timed_out;
	int       exp_roots;
	gf_elem_t gf_exp [0:14];
	int       gf_log [0:15];
	bit       exp_flag [0:`BCH_N-1];

	bch_chien_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.sigma(sigma),
		.accepted(accepted),
		.busy(busy),
		.ready(ready),
		.valid(valid),
		.err_flag(err_flag),
		.position(position),
		.done(done),
		.err_count(err_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// **************************************************
	// Reference field model
	// **************************************************

	task automatic build_field_tables();
		logic [4:0] v;
		v = 5'd1;
		for (int i = 0; i < 15; i++) begin
			gf_exp[i] = v[3:0];
			gf_log[v[3:0]] = i;
			v = v << 1;
			if (v[4]) begin
				v = v ^ 5'h13;                                // Reduce by x^4+x+1.
			end
		end
	endtask

	function automatic gf_elem_t field_mul(gf_elem_t a, gf_elem_t b);
		if (a == 0 || b == 0) begin
			return gf_elem_t'(0);
		end
		return gf_exp[(gf_log[a] + gf_log[b]) % 15];
	endfunction

	// Value of s at alpha^e.
	function automatic gf_elem_t eval_sigma(sigma_t s, int e);
		gf_elem_t acc;
		gf_elem_t xp;
		acc = '0;
		xp = gf_elem_t'(1);
		for (int i = 0; i <= `BCH_T; i++) begin
			acc = acc ^ field_mul(s[i*`BCH_M +: `BCH_M], xp);
			xp = field_mul(xp, gf_exp[e % 15]);
		end
		return acc;
	endfunction

	// Half of the draws have planted roots, the rest are raw random.
	function automatic sigma_t draw_sigma();
		int       a;
		int       b;
		gf_elem_t c;
		gf_elem_t r1;
		gf_elem_t r2;
		c = gf_exp[$urandom % 15];
		a = int'($urandom % 15);
		b = (a + 1 + int'($urandom % 14)) % 15;              // Always differs from a.
		r1 = gf_exp[a];
		r2 = gf_exp[b];
		case ($urandom % 4)
			0: return {gf_elem_t'(0), c, field_mul(c, r1)};
			1: return {c, field_mul(c, r1 ^ r2), field_mul(c, field_mul(r1, r2))};
			default: return sigma_t'($urandom);
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic note_failure(input string msg);
		failures++;
		$display("ERROR: %s at %0t", msg, $time);
	endtask

	// **************************************************
	// One search from start to done
	// **************************************************

	task automatic run_search(input sigma_t s, input bit stray_start);
		int   beats;
		int   waited;
		bit   stray_sent;
		bit   take;
		exp_roots = 0;
		for (int k = 0; k < `BCH_N; k++) begin
			exp_flag[k] = (eval_sigma(s, k + 1) == 0);
			if (exp_flag[k]) begin
				exp_roots++;
			end
		end
		start = 1'b1;                                         // Entered on a falling edge.
		sigma = s;
		accepted = 1'b0;
		@(negedge clk);
		start = 1'b0;
		sigma = sigma_t'($urandom);                           // Must not reach the terms.
		compare_value("busy", busy, 1);
		compare_value("valid", valid, 0);
		compare_value("ready", ready, 0);
		@(negedge clk);
		compare_value("valid", valid, 1);                     // Two cycles after start.
		compare_value("ready", ready, 1);
		beats = 0;
		waited = 0;
		stray_sent = 0;
		while (beats < `BCH_N && waited < BEAT_TIMEOUT) begin
			start = 1'b0;
			if (valid) begin
				compare_value("ready", ready, beats == 0);
				compare_value("err_flag", err_flag, exp_flag[beats]);
				compare_value("position", position, beats);
				take = ($urandom % 100) < 70;
				accepted = take;
				if (take) begin
					beats++;
					waited = 0;
				end else begin
					waited++;
				end
				if (stray_start && !stray_sent && beats == 5) begin
					start = 1'b1;                             // Busy is high, so this is dropped.
					sigma = sigma_t'($urandom);
					stray_sent = 1;
				end
			end else begin
				accepted = 1'($urandom);
				waited++;
			end
			@(negedge clk);
		end
		accepted = 1'b0;
		start = 1'b0;
		assert (beats == `BCH_N) else begin
			note_failure($sformatf("timeout, only %0d of %0d beats arrived", beats, `BCH_N));
			timed_out = 1;
		end
		compare_value("done", done, 1);
		compare_value("valid", valid, 0);
		compare_value("busy", busy, 0);
		compare_value("err_count", err_count, exp_roots);
		@(negedge clk);
		compare_value("done", done, 0);                       // Single pulse only.
		compare_value("valid", valid, 0);
		compare_value("err_count", err_count, exp_roots);
	endtask

	initial begin
		int gap;
		int total;
		start = 1'b0;
		sigma = '0;
		accepted = 1'b0;
		rst_n = 1'b0;
		checks = 0;
		mismatches = 0;
		failures = 0;
		timed_out = 0;
		void'($urandom(32'h08857d5f));
		build_field_tables();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		compare_value("busy", busy, 0);
		compare_value("ready", ready, 0);
		compare_value("valid", valid, 0);
		compare_value("done", done, 0);
		compare_value("err_flag", err_flag, 0);
		compare_value("err_count", err_count, 0);
		for (int run = 0; run < RUNS && !timed_out; run++) begin
			run_search(draw_sigma(), (run % 3) == 1);
			gap = int'($urandom % 4);
			for (int g = 0; g < gap; g++) begin
				@(negedge clk);
				compare_value("done", done, 0);
				compare_value("err_count", err_count, exp_roots);  // Stable until next start.
			end
		end
		total = mismatches + failures + u_dut.u_chk.fail_count;
		$display("Summary: %0d checks, %0d mismatches, %0d other failures, %0d assertion failures",
			checks, mismatches, failures, u_dut.u_chk.fail_count);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+common
common/bch_pkg.sv
hw/gf_mult.sv
hw/lfsr_counter.sv
chien/chien_reg.sv
chien/chien_search.sv
hw/error_locator.sv
hw/bch_chien_top.sv
verif/chien_chk.sv
verif/tb_bch_chien.sv
